// ==== source/axil_pkg.sv ====
`default_nettype none

package axil_pkg;

    // ------------------------------
    // Bus widths
    // ------------------------------
    localparam int axil_addr_width = 32;
    localparam int axil_data_width = 32;
    localparam int axil_strb_width = axil_data_width / 8;
    localparam int axil_prot_width = 3;

    // Address, data and side-band types
    typedef logic [axil_addr_width-1:0] axil_addr_t;
    typedef logic [axil_data_width-1:0] axil_data_t;
    typedef logic [axil_strb_width-1:0] axil_strb_t;
    typedef logic [axil_prot_width-1:0] axil_prot_t;

    // ------------------------------
    // Fixed side-band values
    // ------------------------------
    // Writes go out unprivileged, reads privileged
    localparam axil_prot_t axil_write_prot = 3'b000;
    localparam axil_prot_t axil_read_prot  = 3'b001;

    // Full word writes only
    localparam axil_strb_t axil_full_strb = '1;

endpackage

`default_nettype wire

// ==== source/dma_regs_pkg.sv ====
`default_nettype none

package dma_regs_pkg;

    import axil_pkg::*;

    // ------------------------------
    // DMA engine register map
    // ------------------------------
    localparam axil_addr_t dma_base_addr  = 32'h4040_0000;
    localparam axil_addr_t dma_ctrl_off   = 32'h0000_0000;
    // Status reads and the interrupt clear write share this offset
    localparam axil_addr_t dma_status_off = 32'h0000_0004;
    localparam axil_addr_t dma_sa_off     = 32'h0000_0018;
    localparam axil_addr_t dma_length_off = 32'h0000_0028;

    // Control words
    localparam axil_data_t dma_ctrl_start_word = 32'h0001_1003;  // run + irq enable
    localparam axil_data_t dma_clear_word      = 32'h0001_1001;

    // Status bits
    localparam int dma_status_halted_bit = 0;
    localparam int dma_status_idle_bit   = 1;

    // Transfer length field
    localparam int dma_length_width = 26;
    typedef logic [dma_length_width-1:0] dma_length_t;

    // ------------------------------
    // State machines
    // ------------------------------
    typedef enum logic [2:0] {
        seq_idle, seq_check_idle, seq_program, seq_wait_irq, seq_clear_irq
    } seq_state_t;

    typedef enum logic [2:0] {
        prog_idle, prog_ctrl, prog_sa, prog_length, prog_clear
    } prog_step_t;

endpackage

`default_nettype wire

// ==== source/axil_write_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module axil_write_master
    import axil_pkg::*;
    import dma_regs_pkg::*;
(
    input  wire              M_AXI_ACLK,
    input  wire              M_AXI_ARESETN,
    input  wire              wr_start,
    input  wire axil_addr_t  wr_addr,
    input  wire axil_data_t  wr_data,
    output logic             wr_done,
    output axil_addr_t       m_axi_awaddr,
    output axil_prot_t       m_axi_awprot,
    output logic             m_axi_awvalid,
    input  wire              m_axi_awready,
    output axil_data_t       m_axi_wdata,
    output axil_strb_t       m_axi_wstrb,
    output logic             m_axi_wvalid,
    input  wire              m_axi_wready,
    input  wire [1:0]        m_axi_bresp,
    input  wire              m_axi_bvalid,
    output logic             m_axi_bready
);

    axil_addr_t awaddr_q;
    axil_data_t wdata_q;
    logic       bready_q;
    logic       b_hs;

    assign b_hs = m_axi_bvalid && bready_q;

    // Payload for the current write
    always_ff @(posedge M_AXI_ACLK) begin
        if (wr_start) begin
            awaddr_q <= dma_base_addr + wr_addr;
            wdata_q  <= wr_data;
        end
    end

    // AW and W raise together, drop on their own handshakes
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            m_axi_awvalid <= 1'b0;
            m_axi_wvalid  <= 1'b0;
        end else begin
            if (wr_start) begin
                m_axi_awvalid <= 1'b1;
            end else if (m_axi_awready) begin
                m_axi_awvalid <= 1'b0;
            end
            if (wr_start) begin
                m_axi_wvalid <= 1'b1;
            end else if (m_axi_wready) begin
                m_axi_wvalid <= 1'b0;
            end
        end
    end

    // One cycle bready pulse after bvalid shows up
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            bready_q <= 1'b0;
        end else begin
            bready_q <= m_axi_bvalid && !bready_q;
        end
    end

    assign wr_done      = b_hs;
    assign m_axi_bready = bready_q;
    assign m_axi_awaddr = awaddr_q;
    assign m_axi_awprot = axil_write_prot;
    assign m_axi_wdata  = wdata_q;
    assign m_axi_wstrb  = axil_full_strb;

endmodule

`default_nettype wire

// ==== source/axil_read_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module axil_read_master
    import axil_pkg::*;
(
    input  wire              M_AXI_ACLK,
    input  wire              M_AXI_ARESETN,
    input  wire              rd_start,
    input  wire axil_addr_t  rd_addr,
    output logic             rd_done,
    output axil_data_t       rd_data,
    output axil_addr_t       m_axi_araddr,
    output axil_prot_t       m_axi_arprot,
    output logic             m_axi_arvalid,
    input  wire              m_axi_arready,
    input  wire axil_data_t  m_axi_rdata,
    input  wire [1:0]        m_axi_rresp,
    input  wire              m_axi_rvalid,
    output logic             m_axi_rready
);

    logic r_hs;

    assign r_hs = m_axi_rvalid && m_axi_rready;

    always_ff @(posedge M_AXI_ACLK) begin
        if (rd_start) begin
            m_axi_araddr <= rd_addr;
        end
        if (r_hs) begin
            rd_data <= m_axi_rdata;
        end
    end

    // AR held until the slave takes it, rready pulses once per beat
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            m_axi_arvalid <= 1'b0;
            m_axi_rready  <= 1'b0;
            rd_done       <= 1'b0;
        end else begin
            if (rd_start) begin
                m_axi_arvalid <= 1'b1;
            end else if (m_axi_arready) begin
                m_axi_arvalid <= 1'b0;
            end
            m_axi_rready <= m_axi_rvalid && !m_axi_rready;
            rd_done      <= r_hs;
        end
    end

    assign m_axi_arprot = axil_read_prot;

endmodule

`default_nettype wire

// ==== source/dma_reg_programmer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_reg_programmer
    import axil_pkg::*;
    import dma_regs_pkg::*;
(
    input  wire               M_AXI_ACLK,
    input  wire               M_AXI_ARESETN,
    input  wire               prog_start,
    input  wire               clear_start,
    input  wire axil_data_t   sa,
    input  wire dma_length_t  length,
    output logic              prog_done,
    output logic              clear_done,
    output logic              wr_start,
    output axil_addr_t        wr_addr,
    output axil_data_t        wr_data,
    input  wire               wr_done
);

    prog_step_t step;
    prog_step_t next_step;
    logic       advance;
    logic       issue;

    // Each step waits for the previous write to complete
    always_comb begin
        next_step = step;
        case (step)
            prog_idle: begin
                if (prog_start) begin
                    next_step = prog_ctrl;
                end else if (clear_start) begin
                    next_step = prog_clear;
                end
            end
            prog_ctrl: if (wr_done) next_step = prog_sa;
            prog_sa: if (wr_done) next_step = prog_length;
            prog_length, prog_clear: if (wr_done) next_step = prog_idle;
            default: next_step = prog_idle;
        endcase
    end

    assign advance = next_step != step;
    assign issue   = advance && (next_step != prog_idle);

    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            step       <= prog_idle;
            wr_start   <= 1'b0;
            prog_done  <= 1'b0;
            clear_done <= 1'b0;
        end else begin
            step       <= next_step;
            wr_start   <= issue;
            prog_done  <= advance && (step == prog_length);
            clear_done <= advance && (step == prog_clear);
        end
    end

    // ------------------------------
    // Offset and word per step
    // ------------------------------
    always_ff @(posedge M_AXI_ACLK) begin
        if (issue) begin
            case (next_step)
                prog_ctrl: begin
                    wr_addr <= dma_ctrl_off;
                    wr_data <= dma_ctrl_start_word;
                end
                prog_sa: begin
                    wr_addr <= dma_sa_off;
                    wr_data <= sa;
                end
                prog_length: begin
                    wr_addr <= dma_length_off;
                    wr_data <= axil_data_t'(length);
                end
                default: begin
                    wr_addr <= dma_status_off;
                    wr_data <= dma_clear_word;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/dma_read_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_read_sequencer
    import axil_pkg::*;
    import dma_regs_pkg::*;
(
    input  wire               M_AXI_ACLK,
    input  wire               M_AXI_ARESETN,
    input  wire axil_data_t   dma_sa_config,
    input  wire dma_length_t  dma_length_config,
    input  wire               dma_read_valid,
    input  wire               dma_read_irq,
    output logic              dma_idle,
    output axil_data_t        cfg_sa,
    output dma_length_t       cfg_length,
    output logic              prog_start,
    output logic              clear_start,
    input  wire               prog_done,
    input  wire               clear_done,
    output logic              rd_start,
    input  wire               rd_done,
    input  wire axil_data_t   rd_data
);

    seq_state_t state;
    logic       rd_pending;
    logic       clear_seen;
    logic       idle_q;
    logic       status_ready;
    logic       clear_finished;

    // Engine is halted or idle, safe to program
    assign status_ready   = rd_data[dma_status_halted_bit] || rd_data[dma_status_idle_bit];
    assign clear_finished = clear_done || clear_seen;

    // ------------------------------
    // Main FSM
    // ------------------------------
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            state <= seq_idle;
        end else begin
            case (state)
                seq_idle: if (dma_read_valid) state <= seq_check_idle;
                seq_check_idle: if (rd_done && status_ready) state <= seq_program;
                seq_program: if (prog_done) state <= seq_wait_irq;
                seq_wait_irq: if (dma_read_irq) state <= seq_clear_irq;
                seq_clear_irq: if (clear_finished && !dma_read_irq) state <= seq_idle;
                default: state <= seq_idle;
            endcase
        end
    end

    // Config held for the whole transfer
    always_ff @(posedge M_AXI_ACLK) begin
        if ((state == seq_idle) && dma_read_valid) begin
            cfg_sa     <= dma_sa_config;
            cfg_length <= dma_length_config;
        end
    end

    // Status polling, one read in flight at a time
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            rd_start   <= 1'b0;
            rd_pending <= 1'b0;
        end else begin
            rd_start <= (state == seq_check_idle) && !rd_pending && !rd_start;
            if (rd_start) begin
                rd_pending <= 1'b1;
            end else if (rd_done) begin
                rd_pending <= 1'b0;
            end
        end
    end

    // Strobes to the programmer, plus clear completion tracking
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            prog_start  <= 1'b0;
            clear_start <= 1'b0;
            clear_seen  <= 1'b0;
            idle_q      <= 1'b0;
        end else begin
            prog_start  <= (state == seq_check_idle) && rd_done && status_ready;
            clear_start <= (state == seq_wait_irq) && dma_read_irq;
            if (state != seq_clear_irq) begin
                clear_seen <= 1'b0;
            end else if (clear_done) begin
                clear_seen <= 1'b1;
            end
            idle_q <= state == seq_idle;
        end
    end

    // A new request hides the idle flag at once
    assign dma_idle = idle_q && !dma_read_valid;

endmodule

`default_nettype wire

// ==== source/dma_read_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_read_ctrl_top
    import axil_pkg::*;
    import dma_regs_pkg::*;
(
    input  wire               M_AXI_ACLK,
    input  wire               M_AXI_ARESETN,
    input  wire axil_data_t   dma_sa_config,
    input  wire dma_length_t  dma_length_config,
    input  wire               dma_read_valid,
    input  wire               dma_read_irq,
    output logic              dma_idle,
    output axil_addr_t        m_axi_awaddr,
    output axil_prot_t        m_axi_awprot,
    output logic              m_axi_awvalid,
    input  wire               m_axi_awready,
    output axil_data_t        m_axi_wdata,
    output axil_strb_t        m_axi_wstrb,
    output logic              m_axi_wvalid,
    input  wire               m_axi_wready,
    input  wire [1:0]         m_axi_bresp,
    input  wire               m_axi_bvalid,
    output logic              m_axi_bready,
    output axil_addr_t        m_axi_araddr,
    output axil_prot_t        m_axi_arprot,
    output logic              m_axi_arvalid,
    input  wire               m_axi_arready,
    input  wire axil_data_t   m_axi_rdata,
    input  wire [1:0]         m_axi_rresp,
    input  wire               m_axi_rvalid,
    output logic              m_axi_rready
);

    axil_data_t  cfg_sa;
    dma_length_t cfg_length;
    logic        prog_start;
    logic        clear_start;
    logic        prog_done;
    logic        clear_done;
    logic        rd_start;
    logic        rd_done;
    axil_data_t  rd_data;
    logic        wr_start;
    axil_addr_t  wr_addr;
    axil_data_t  wr_data;
    logic        wr_done;

    dma_read_sequencer u_sequencer (
        .M_AXI_ACLK, .M_AXI_ARESETN, .dma_sa_config, .dma_length_config,
        .dma_read_valid, .dma_read_irq, .dma_idle, .cfg_sa, .cfg_length,
        .prog_start, .clear_start, .prog_done, .clear_done,
        .rd_start, .rd_done, .rd_data
    );

    dma_reg_programmer u_programmer (
        .M_AXI_ACLK, .M_AXI_ARESETN, .prog_start, .clear_start,
        .sa(cfg_sa), .length(cfg_length), .prog_done, .clear_done,
        .wr_start, .wr_addr, .wr_data, .wr_done
    );

    axil_write_master u_write_master (
        .M_AXI_ACLK, .M_AXI_ARESETN, .wr_start, .wr_addr, .wr_data, .wr_done,
        .m_axi_awaddr, .m_axi_awprot, .m_axi_awvalid, .m_axi_awready,
        .m_axi_wdata, .m_axi_wstrb, .m_axi_wvalid, .m_axi_wready,
        .m_axi_bresp, .m_axi_bvalid, .m_axi_bready
    );

    // Status polls always target the status register
    axil_read_master u_read_master (
        .M_AXI_ACLK, .M_AXI_ARESETN, .rd_start,
        .rd_addr(dma_base_addr + dma_status_off), .rd_done, .rd_data,
        .m_axi_araddr, .m_axi_arprot, .m_axi_arvalid, .m_axi_arready,
        .m_axi_rdata, .m_axi_rresp, .m_axi_rvalid, .m_axi_rready
    );

endmodule

`default_nettype wire

// ==== sim/dma_read_ctrl_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_read_ctrl_assertions
    import axil_pkg::*;
    import dma_regs_pkg::*;
(
    input  wire              M_AXI_ACLK,
    input  wire              M_AXI_ARESETN,
    input  wire              dma_read_valid,
    input  wire              dma_read_irq,
    input  wire              dma_idle,
    input  wire axil_addr_t  m_axi_awaddr,
    input  wire axil_prot_t  m_axi_awprot,
    input  wire              m_axi_awvalid,
    input  wire              m_axi_awready,
    input  wire axil_data_t  m_axi_wdata,
    input  wire axil_strb_t  m_axi_wstrb,
    input  wire              m_axi_wvalid,
    input  wire              m_axi_wready,
    input  wire              m_axi_bready,
    input  wire axil_addr_t  m_axi_araddr,
    input  wire axil_prot_t  m_axi_arprot,
    input  wire              m_axi_arvalid,
    input  wire              m_axi_arready,
    input  wire              m_axi_rready
);

    // Raised by any failing property below
    logic failed = 1'b0;

    // ------------------------------
    // Reset and handshake rules
    // ------------------------------
    a_reset_quiet: assert property (@(posedge M_AXI_ACLK)
        !M_AXI_ARESETN |=> !(m_axi_awvalid || m_axi_wvalid || m_axi_bready
                             || m_axi_arvalid || m_axi_rready))
    else begin
        $error("AXI valid or ready output active right after reset");
        failed = 1'b1;
    end

    a_aw_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        m_axi_awvalid && !m_axi_awready |=> m_axi_awvalid && $stable(m_axi_awaddr))
    else begin
        $error("awvalid or awaddr changed before awready");
        failed = 1'b1;
    end

    a_w_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        m_axi_wvalid && !m_axi_wready |=> m_axi_wvalid && $stable(m_axi_wdata))
    else begin
        $error("wvalid or wdata changed before wready");
        failed = 1'b1;
    end

    a_ar_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        m_axi_arvalid && !m_axi_arready |=> m_axi_arvalid && $stable(m_axi_araddr))
    else begin
        $error("arvalid or araddr changed before arready");
        failed = 1'b1;
    end

    // Side band values and the poll address
    a_write_side: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        (m_axi_awvalid |-> m_axi_awprot == 3'd0) and (m_axi_wvalid |-> m_axi_wstrb == 4'hf))
    else begin
        $error("awprot or wstrb has a wrong value");
        failed = 1'b1;
    end

    a_read_side: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        m_axi_arvalid |-> m_axi_arprot == 3'd1 && m_axi_araddr == dma_base_addr + 32'h4)
    else begin
        $error("arprot or araddr has a wrong value");
        failed = 1'b1;
    end

    // No idle report during a request or while the interrupt is up
    a_idle_flag: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        dma_read_valid || dma_read_irq |-> !dma_idle)
    else begin
        $error("dma_idle high during a request or an interrupt");
        failed = 1'b1;
    end

endmodule

bind dma_read_ctrl_top dma_read_ctrl_assertions u_assertions (.*);

`default_nettype wire

// ==== sim/tb_dma_read_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dma_read_ctrl
    import axil_pkg::*;
    import dma_regs_pkg::*;
();

    // Worst case near 250 cycles per transfer, two transfers, four times margin
    localparam int cycle_limit = 4 * 2 * 250;

    logic        M_AXI_ACLK = 1'b0;
    logic        M_AXI_ARESETN;
    axil_data_t  dma_sa_config;
    dma_length_t dma_length_config;
    logic        dma_read_valid;
    logic        dma_read_irq = 1'b0;
    wire         dma_idle;
    wire axil_addr_t m_axi_awaddr;
    wire axil_prot_t m_axi_awprot;
    wire         m_axi_awvalid;
    logic        m_axi_awready = 1'b0;
    wire axil_data_t m_axi_wdata;
    wire axil_strb_t m_axi_wstrb;
    wire         m_axi_wvalid;
    logic        m_axi_wready = 1'b0;
    logic [1:0]  m_axi_bresp = 2'b00;
    logic        m_axi_bvalid = 1'b0;
    wire         m_axi_bready;
    wire axil_addr_t m_axi_araddr;
    wire axil_prot_t m_axi_arprot;
    wire         m_axi_arvalid;
    logic        m_axi_arready = 1'b0;
    axil_data_t  m_axi_rdata = '0;
    logic [1:0]  m_axi_rresp = 2'b00;
    logic        m_axi_rvalid = 1'b0;
    wire         m_axi_rready;

    // Slave model state and write log
    int seed = 29;
    int cycles = 0;
    int aw_cnt = 0;
    int w_cnt = 0;
    int b_cnt = 0;
    int ar_cnt = 0;
    int r_cnt = 0;
    int irq_raise_cnt = -1;
    int irq_drop_cnt = -1;
    int wr_count = 0;
    int irq_mark = 0;
    int status_reads = 0;
    bit aw_got = 1'b0;
    bit w_got = 1'b0;
    bit r_due = 1'b0;
    bit status_ok = 1'b0;
    axil_addr_t got_addr;
    axil_data_t got_data;
    axil_addr_t wr_addr_log [0:15];
    axil_data_t wr_data_log [0:15];

    dma_read_ctrl_top UUT (.*);

    always #4 M_AXI_ACLK = ~M_AXI_ACLK;

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic expect_word(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else begin
            report_failure($sformatf("** Error [%s] expected 0x%08h actual 0x%08h",
                                     test, expected, actual));
        end
    endtask

    function automatic int next_delay();
        return $unsigned($random(seed)) % 4;
    endfunction

    // Counts a channel's wait down, true once it has run out
    function automatic bit wait_over(inout int cnt);
        if (cnt == 0) begin
            return 1'b1;
        end
        cnt--;
        return 1'b0;
    endfunction

    task automatic next_cycle();
        @(posedge M_AXI_ACLK);
        #1;
    endtask

    // ------------------------------
    // AXI4-Lite slave model
    // ------------------------------
    always @(posedge M_AXI_ACLK) begin : slave_model
        logic aw_hs, w_hs, b_hs, ar_hs, r_hs;
        logic aw_pend, w_pend, ar_pend;
        aw_hs   = m_axi_awvalid && m_axi_awready;
        w_hs    = m_axi_wvalid && m_axi_wready;
        b_hs    = m_axi_bvalid && m_axi_bready;
        ar_hs   = m_axi_arvalid && m_axi_arready;
        r_hs    = m_axi_rvalid && m_axi_rready;
        aw_pend = m_axi_awvalid && !m_axi_awready;
        w_pend  = m_axi_wvalid && !m_axi_wready;
        ar_pend = m_axi_arvalid && !m_axi_arready;
        if (aw_hs) begin
            assert (status_ok)
            else report_failure("A write was accepted before a poll showed halted or idle");
            got_addr = m_axi_awaddr;
        end
        if (w_hs) begin
            got_data = m_axi_wdata;
        end
        #1;
        // Interrupt line of the engine
        if (irq_raise_cnt > 0) begin
            irq_raise_cnt--;
        end else if (irq_raise_cnt == 0) begin
            dma_read_irq  = 1'b1;
            irq_mark      = wr_count;
            irq_raise_cnt = -1;
        end
        if (irq_drop_cnt > 0) begin
            irq_drop_cnt--;
        end else if (irq_drop_cnt == 0) begin
            dma_read_irq = 1'b0;
            irq_drop_cnt = -1;
        end
        if (aw_hs) begin
            m_axi_awready = 1'b0;
            aw_cnt = next_delay();
            aw_got = 1'b1;
        end else if (aw_pend && wait_over(aw_cnt)) begin
            m_axi_awready = 1'b1;
        end
        if (w_hs) begin
            m_axi_wready = 1'b0;
            w_cnt = next_delay();
            w_got = 1'b1;
        end else if (w_pend && wait_over(w_cnt)) begin
            m_axi_wready = 1'b1;
        end
        if (b_hs) begin
            m_axi_bvalid = 1'b0;
            b_cnt = next_delay();
            aw_got = 1'b0;
            w_got = 1'b0;
            wr_addr_log[wr_count] = got_addr;
            wr_data_log[wr_count] = got_data;
            wr_count++;
            if (got_addr == dma_base_addr + 32'h28) begin
                irq_raise_cnt = 20;
            end
            // The clear write ends the transfer
            if (got_addr == dma_base_addr + 32'h04) begin
                irq_drop_cnt = 5;
                status_reads = 0;
                status_ok = 1'b0;
            end
        end else if (aw_got && w_got && !m_axi_bvalid && wait_over(b_cnt)) begin
            m_axi_bvalid = 1'b1;
        end
        if (ar_hs) begin
            m_axi_arready = 1'b0;
            ar_cnt = next_delay();
            r_due = 1'b1;
        end else if (ar_pend && wait_over(ar_cnt)) begin
            m_axi_arready = 1'b1;
        end
        if (r_hs) begin
            m_axi_rvalid = 1'b0;
            r_cnt = next_delay();
            status_ok = status_ok || m_axi_rdata[0] || m_axi_rdata[1];
        end else if (r_due && wait_over(r_cnt)) begin
            // Busy twice, then idle
            m_axi_rdata  = (status_reads < 2) ? 32'h0 : 32'h2;
            m_axi_rvalid = 1'b1;
            r_due = 1'b0;
            status_reads++;
        end
    end

    always @(posedge M_AXI_ACLK) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            report_failure("Timeout, the transfers did not finish within the cycle limit");
        end
        if (UUT.u_assertions.failed) begin
            report_failure("A protocol assertion on the DUT ports failed");
        end
    end

    // ------------------------------
    // One read transfer and its checks
    // ------------------------------
    task automatic run_transfer(input int num, input axil_data_t sa, input dma_length_t len,
                                input bit move_sa);
        int first;
        string tag;
        first = wr_count;
        tag = $sformatf("xfer%0d", num);
        dma_sa_config     = sa;
        dma_length_config = len;
        dma_read_valid    = 1'b1;
        next_cycle();
        dma_read_valid = 1'b0;
        if (move_sa) begin
            dma_sa_config = ~sa;
        end
        while (dma_idle) begin
            next_cycle();
        end
        while (!dma_idle) begin
            next_cycle();
        end
        expect_word({tag, " write count"}, 4, wr_count - first);
        expect_word({tag, " ctrl addr"}, dma_base_addr + 32'h00, wr_addr_log[first]);
        expect_word({tag, " ctrl data"}, 32'h0001_1003, wr_data_log[first]);
        expect_word({tag, " sa addr"}, dma_base_addr + 32'h18, wr_addr_log[first+1]);
        expect_word({tag, " sa data"}, sa, wr_data_log[first+1]);
        expect_word({tag, " length addr"}, dma_base_addr + 32'h28, wr_addr_log[first+2]);
        expect_word({tag, " length data"}, {6'd0, len}, wr_data_log[first+2]);
        expect_word({tag, " writes after irq"}, 1, wr_count - irq_mark);
        expect_word({tag, " clear addr"}, dma_base_addr + 32'h04, wr_addr_log[first+3]);
        expect_word({tag, " clear data"}, 32'h0001_1001, wr_data_log[first+3]);
    endtask

    initial begin
        M_AXI_ARESETN     = 1'b0;
        dma_sa_config     = '0;
        dma_length_config = '0;
        dma_read_valid    = 1'b0;
        repeat (3) @(posedge M_AXI_ACLK);
        #1;
        M_AXI_ARESETN = 1'b1;
        expect_word("reset idle first cycle", 0, dma_idle);
        expect_word("reset outputs low", 0, {m_axi_awvalid, m_axi_wvalid, m_axi_bready,
                                             m_axi_arvalid, m_axi_rready});
        next_cycle();
        expect_word("reset idle second cycle", 1, dma_idle);
        run_transfer(1, 32'h8000_1000, 26'h012_3456, 1'b1);
        run_transfer(2, 32'h9abc_0040, 26'h3ff_ffff, 1'b0);
        if (!UUT.u_assertions.failed) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            report_failure("A protocol assertion on the DUT ports failed");
        end
    end

endmodule

`default_nettype wire

// ==== files.f ====
source/axil_pkg.sv
source/dma_regs_pkg.sv
source/axil_write_master.sv
source/axil_read_master.sv
source/dma_reg_programmer.sv
source/dma_read_sequencer.sv
source/dma_read_ctrl_top.sv
sim/dma_read_ctrl_assertions.sv
sim/tb_dma_read_ctrl.sv
